/* verilog/uart_params.svh */
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

`default_nettype none

// channel count and index width
`define UART_NUM_CH 4
`define UART_CH_W 2

// clocks per oversample tick
`define UART_TICK_DIV 4

// ticks per bit, so one bit is 32 clocks
`define UART_OSR 8

// start, 8 data, parity, stop
`define UART_FRAME_BITS 11

`default_nettype wire

`endif

/* verilog/uart_pkg.sv */
`include "uart_params.svh"
`default_nettype none

package uart_pkg;

  typedef logic [15:0] cmd_word_t;
  typedef logic [7:0] uart_byte_t;

  // parity_err in bit 8, byte below
  typedef logic [8:0] read_word_t;

  typedef logic [`UART_CH_W-1:0] chan_idx_t;

  typedef enum logic [2:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_PARITY,
    TX_STOP
  } tx_state_e;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_PARITY,
    RX_STOP
  } rx_state_e;

endpackage

`default_nettype wire

/* verilog/baud_tick_gen.sv */
`timescale 1ns/100ps
`include "uart_params.svh"
`default_nettype none

module baud_tick_gen (
  input  wire  clk,
  input  wire  rst_n,
  output logic tick
);

  localparam int CNT_W = $clog2(`UART_TICK_DIV);

  logic [CNT_W-1:0] cnt;
  logic             cnt_wrap;

  assign cnt_wrap = (cnt == CNT_W'(`UART_TICK_DIV - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tick <= 1'b0;
    end else begin
      tick <= cnt_wrap;
      if (cnt_wrap) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  // every tx and rx counts these, a double tick would shorten a bit
  a_tick_single: assert property (
    @(posedge clk) disable iff (!rst_n)
    tick |=> !tick
  );

endmodule

`default_nettype wire

/* verilog/cmd_dispatch.sv */
`timescale 1ns/100ps
`include "uart_params.svh"
`default_nettype none

module cmd_dispatch (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire uart_pkg::cmd_word_t     cmd_in,
  input  wire uart_pkg::chan_idx_t     cmd_ch,
  input  wire                          cmd_vld,
  output logic                         cmd_rdy,
  input  wire  [`UART_NUM_CH-1:0]      busy,
  output logic [`UART_NUM_CH-1:0]      load,
  output uart_pkg::cmd_word_t          load_word
);

  logic cmd_fire;

  // load doubles as the mask until busy comes up
  assign cmd_rdy  = !busy[cmd_ch] && !load[cmd_ch];
  assign cmd_fire = cmd_vld && cmd_rdy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load <= '0;
    end else begin
      load <= '0;
      if (cmd_fire) begin
        load[cmd_ch] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      load_word <= cmd_in;
    end
  end

  // one strobe at a time, and never into a sending channel
  a_load_ok: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(load) && ((load & busy) == '0)
  );

  // the addressed transmitter must pick the strobe up
  a_load_busy: assert property (
    @(posedge clk) disable iff (!rst_n)
    (load != '0) |=> ((busy & $past(load)) == $past(load))
  );

endmodule

`default_nettype wire

/* verilog/uart_tx_frame.sv */
`timescale 1ns/100ps
`include "uart_params.svh"
`default_nettype none

module uart_tx_frame (
  input  wire                      clk,
  input  wire                      rst_n,
  input  wire                      tick,
  input  wire                      load,
  input  wire uart_pkg::cmd_word_t load_word,
  output logic                     busy,
  output logic                     tx
);

  localparam int CNT_W = $clog2(`UART_OSR);

  uart_pkg::tx_state_e  state;
  uart_pkg::cmd_word_t  word_q;
  uart_pkg::uart_byte_t cur_byte;
  logic [CNT_W-1:0]     tick_cnt;
  logic [2:0]           bit_cnt;
  logic                 low_half;
  logic                 bit_end;

  // high byte first
  assign cur_byte = low_half ? word_q[7:0] : word_q[15:8];
  assign bit_end  = tick && (tick_cnt == CNT_W'(`UART_OSR - 1));

  always_ff @(posedge clk) begin
    if (load) begin
      word_q <= load_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::TX_IDLE;
      busy     <= 1'b0;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      low_half <= 1'b0;
    end else begin
      if (load) begin
        busy <= 1'b1;
      end
      if (state == uart_pkg::TX_IDLE) begin
        tick_cnt <= '0;
      end else if (tick) begin
        tick_cnt <= bit_end ? '0 : tick_cnt + 1'b1;
      end
      case (state)
        uart_pkg::TX_IDLE: begin
          // start bit lines up with the next tick
          if (busy && tick) begin
            state <= uart_pkg::TX_START;
          end
        end
        uart_pkg::TX_START: begin
          if (bit_end) begin
            state   <= uart_pkg::TX_DATA;
            bit_cnt <= '0;
          end
        end
        uart_pkg::TX_DATA: begin
          if (bit_end) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::TX_PARITY;
            end
          end
        end
        uart_pkg::TX_PARITY: begin
          if (bit_end) begin
            state <= uart_pkg::TX_STOP;
          end
        end
        uart_pkg::TX_STOP: begin
          if (bit_end) begin
            if (low_half) begin
              state    <= uart_pkg::TX_IDLE;
              busy     <= 1'b0;
              low_half <= 1'b0;
            end else begin
              // second frame straight after the first stop bit
              state    <= uart_pkg::TX_START;
              low_half <= 1'b1;
            end
          end
        end
        default: state <= uart_pkg::TX_IDLE;
      endcase
    end
  end

  always_comb begin
    case (state)
      uart_pkg::TX_START:  tx = 1'b0;
      uart_pkg::TX_DATA:   tx = cur_byte[bit_cnt];
      uart_pkg::TX_PARITY: tx = ~^cur_byte;
      default:             tx = 1'b1;
    endcase
  end

  a_idle_line_high: assert property (
    @(posedge clk) disable iff (!rst_n)
    !busy |-> tx
  );

endmodule

`default_nettype wire

/* verilog/uart_rx_frame.sv */
`timescale 1ns/100ps
`include "uart_params.svh"
`default_nettype none

module uart_rx_frame (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   tick,
  input  wire                   rx,
  output logic                  byte_vld,
  output uart_pkg::uart_byte_t  byte_data,
  output logic                  byte_perr
);

  localparam int CNT_W = $clog2(`UART_OSR);

  uart_pkg::rx_state_e  state;
  uart_pkg::uart_byte_t data_q;
  logic [1:0]           rx_sync;
  logic                 rx_s;
  logic                 rx_prev;
  logic [CNT_W-1:0]     tick_cnt;
  logic [CNT_W-1:0]     cnt_last;
  logic [2:0]           bit_cnt;
  logic                 perr_q;
  logic                 sample;

  assign rx_s = rx_sync[1];

  // half a bit to the middle of start, then whole bits
  assign cnt_last = (state == uart_pkg::RX_START) ? CNT_W'(`UART_OSR / 2 - 1)
                                                  : CNT_W'(`UART_OSR - 1);
  assign sample   = tick && (tick_cnt == cnt_last);

  assign byte_data = data_q;
  assign byte_perr = perr_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_sync <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk) begin
    if (sample && state == uart_pkg::RX_DATA) begin
      data_q <= {rx_s, data_q[7:1]};
    end
    if (sample && state == uart_pkg::RX_PARITY) begin
      perr_q <= (rx_s != ~^data_q);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::RX_IDLE;
      tick_cnt <= '0;
      bit_cnt  <= '0;
      byte_vld <= 1'b0;
    end else begin
      byte_vld <= 1'b0;
      if (state == uart_pkg::RX_IDLE) begin
        tick_cnt <= '0;
      end else if (tick) begin
        tick_cnt <= sample ? '0 : tick_cnt + 1'b1;
      end
      case (state)
        uart_pkg::RX_IDLE: begin
          if (rx_prev && !rx_s) begin
            state <= uart_pkg::RX_START;
          end
        end
        uart_pkg::RX_START: begin
          if (sample) begin
            bit_cnt <= '0;
            // line back high means a glitch
            state   <= rx_s ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
          end
        end
        uart_pkg::RX_DATA: begin
          if (sample) begin
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
              state <= uart_pkg::RX_PARITY;
            end
          end
        end
        uart_pkg::RX_PARITY: begin
          if (sample) begin
            state <= uart_pkg::RX_STOP;
          end
        end
        uart_pkg::RX_STOP: begin
          if (sample) begin
            // low stop bit drops the frame
            byte_vld <= rx_s;
            state    <= uart_pkg::RX_IDLE;
          end
        end
        default: state <= uart_pkg::RX_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/read_arbiter.sv */
`timescale 1ns/100ps
`include "uart_params.svh"
`default_nettype none

module read_arbiter (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire  [`UART_NUM_CH-1:0]   byte_vld,
  input  wire uart_pkg::uart_byte_t byte_data [`UART_NUM_CH],
  input  wire  [`UART_NUM_CH-1:0]   byte_perr,
  output logic                      read_rdy,
  output uart_pkg::read_word_t      read_data,
  output uart_pkg::chan_idx_t       read_ch
);

  localparam uart_pkg::chan_idx_t LAST_CH = uart_pkg::chan_idx_t'(`UART_NUM_CH - 1);

  logic [`UART_NUM_CH-1:0] full;
  uart_pkg::read_word_t    hold [`UART_NUM_CH];
  uart_pkg::chan_idx_t     last_ch;
  uart_pkg::chan_idx_t     gnt_ch;
  logic                    gnt_vld;

  // search starts one past the last grant
  always_comb begin
    uart_pkg::chan_idx_t cand;
    gnt_vld = 1'b0;
    gnt_ch  = last_ch;
    cand    = last_ch;
    for (int k = 0; k < `UART_NUM_CH; k++) begin
      cand = (cand == LAST_CH) ? '0 : cand + 1'b1;
      if (!gnt_vld && full[cand]) begin
        gnt_vld = 1'b1;
        gnt_ch  = cand;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full <= '0;
    end else begin
      for (int i = 0; i < `UART_NUM_CH; i++) begin
        if (byte_vld[i]) begin
          full[i] <= 1'b1;
        end else if (gnt_vld && gnt_ch == uart_pkg::chan_idx_t'(i)) begin
          full[i] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < `UART_NUM_CH; i++) begin
      if (byte_vld[i]) begin
        hold[i] <= {byte_perr[i], byte_data[i]};
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_rdy <= 1'b0;
      last_ch  <= LAST_CH;
    end else begin
      read_rdy <= gnt_vld;
      if (gnt_vld) begin
        last_ch <= gnt_ch;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (gnt_vld) begin
      read_data <= hold[gnt_ch];
      read_ch   <= gnt_ch;
    end
  end

  // a receiver must never outrun its hold register
  a_no_overrun: assert property (
    @(posedge clk) disable iff (!rst_n)
    (byte_vld & full) == '0
  );

endmodule

`default_nettype wire

/* verilog/uart_cmd_top.sv */
`timescale 1ns/100ps
`include "uart_params.svh"
`default_nettype none

module uart_cmd_top (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire uart_pkg::cmd_word_t  cmd_in,
  input  wire uart_pkg::chan_idx_t  cmd_ch,
  input  wire                       cmd_vld,
  output logic                      cmd_rdy,
  output logic [`UART_NUM_CH-1:0]   tx,
  input  wire  [`UART_NUM_CH-1:0]   rx,
  output logic                      read_rdy,
  output uart_pkg::read_word_t      read_data,
  output uart_pkg::chan_idx_t       read_ch
);

  wire                       tick;
  wire [`UART_NUM_CH-1:0]    load;
  wire uart_pkg::cmd_word_t  load_word;
  wire [`UART_NUM_CH-1:0]    busy;
  wire [`UART_NUM_CH-1:0]    byte_vld;
  wire uart_pkg::uart_byte_t byte_data [`UART_NUM_CH];
  wire [`UART_NUM_CH-1:0]    byte_perr;

  baud_tick_gen u_tick (
    .clk   (clk),
    .rst_n (rst_n),
    .tick  (tick)
  );

  cmd_dispatch u_dispatch (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_ch    (cmd_ch),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .busy      (busy),
    .load      (load),
    .load_word (load_word)
  );

  // one transmitter and one receiver per channel
  for (genvar i = 0; i < `UART_NUM_CH; i++) begin : g_ch
    uart_tx_frame u_tx (
      .clk       (clk),
      .rst_n     (rst_n),
      .tick      (tick),
      .load      (load[i]),
      .load_word (load_word),
      .busy      (busy[i]),
      .tx        (tx[i])
    );

    uart_rx_frame u_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .tick      (tick),
      .rx        (rx[i]),
      .byte_vld  (byte_vld[i]),
      .byte_data (byte_data[i]),
      .byte_perr (byte_perr[i])
    );
  end

  read_arbiter u_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .byte_vld  (byte_vld),
    .byte_data (byte_data),
    .byte_perr (byte_perr),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_ch   (read_ch)
  );

endmodule

`default_nettype wire

/* sim/tb_uart_cmd.sv */
`timescale 1ns/100ps
`include "uart_params.svh"
`default_nettype none

module tb_uart_cmd;

  localparam int NUM_CH      = `UART_NUM_CH;
  localparam int BIT_CLKS    = `UART_OSR * `UART_TICK_DIV;
  localparam int NUM_FRAMES  = 32;
  localparam int WATCHDOG_NS = 2 * NUM_FRAMES * `UART_FRAME_BITS * BIT_CLKS * 10 + 50000;

  logic                 clk = 1'b0;
  logic                 rst_n;
  uart_pkg::cmd_word_t  cmd_in;
  uart_pkg::chan_idx_t  cmd_ch;
  logic                 cmd_vld;
  wire                  cmd_rdy;
  wire [NUM_CH-1:0]     tx;
  wire [NUM_CH-1:0]     rx;
  wire                  read_rdy;
  wire uart_pkg::read_word_t read_data;
  wire uart_pkg::chan_idx_t  read_ch;

  logic [NUM_CH-1:0]    loop_en;
  logic [NUM_CH-1:0]    inj_line;
  logic [31:0]          lcg_state;
  logic                 solo_en;
  uart_pkg::chan_idx_t  solo_ch;

  // per-channel expectations, oldest first
  uart_pkg::uart_byte_t exp_tx [NUM_CH][$];
  uart_pkg::read_word_t exp_rd [NUM_CH][$];

  always #5 clk = ~clk;

  // rx is either the channel's own tx or the injected line
  assign rx = (tx & loop_en) | (inj_line & ~loop_en);

  uart_cmd_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_ch    (cmd_ch),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .tx        (tx),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data),
    .read_ch   (read_ch)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_byte(input string name, input uart_pkg::uart_byte_t got,
                            input uart_pkg::uart_byte_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_read(input string name, input uart_pkg::read_word_t got,
                            input uart_pkg::read_word_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_chan(input string name, input uart_pkg::chan_idx_t got,
                            input uart_pkg::chan_idx_t exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      fail_run($sformatf("ERROR %s: got %h, expected %h", name, got, exp));
    end
  endtask

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // parity bit that makes the ones count over data plus parity odd
  function automatic logic odd_parity(input uart_pkg::uart_byte_t b);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      ones += int'(b[i]);
    end
    return (ones % 2 == 0);
  endfunction

  function automatic uart_pkg::read_word_t frame_expect(input uart_pkg::uart_byte_t b,
                                                        input logic corrupt);
    logic sent_par;
    logic perr;
    sent_par = odd_parity(b) ^ corrupt;
    perr     = (sent_par != odd_parity(b));
    return {perr, b};
  endfunction

  function automatic bit all_drained();
    for (int ch = 0; ch < NUM_CH; ch++) begin
      if (exp_tx[ch].size() != 0 || exp_rd[ch].size() != 0) begin
        return 1'b0;
      end
    end
    return 1'b1;
  endfunction

  // holds cmd_vld until the channel takes the command
  task automatic issue_cmd(input int ch, input uart_pkg::cmd_word_t word);
    @(posedge clk);
    #1;
    cmd_in  = word;
    cmd_ch  = uart_pkg::chan_idx_t'(ch);
    cmd_vld = 1'b1;
    @(negedge clk);
    while (cmd_rdy !== 1'b1) begin
      @(negedge clk);
    end
    if (exp_tx[ch].size() != 0) begin
      fail_run($sformatf("channel %0d accepted a command while still sending", ch));
    end
    exp_tx[ch].push_back(word[15:8]);
    exp_tx[ch].push_back(word[7:0]);
    if (loop_en[ch]) begin
      exp_rd[ch].push_back(frame_expect(word[15:8], 1'b0));
      exp_rd[ch].push_back(frame_expect(word[7:0], 1'b0));
    end
    @(posedge clk);
    #1;
    cmd_vld = 1'b0;
  endtask

  task automatic line_bit(input int ch, input logic v);
    @(posedge clk);
    #1;
    inj_line[ch] = v;
    repeat (BIT_CLKS - 1) @(posedge clk);
  endtask

  task automatic send_serial(input int ch, input uart_pkg::uart_byte_t b, input logic corrupt);
    logic par;
    par = odd_parity(b) ^ corrupt;
    exp_rd[ch].push_back(frame_expect(b, corrupt));
    line_bit(ch, 1'b0);
    for (int i = 0; i < 8; i++) begin
      line_bit(ch, b[i]);
    end
    line_bit(ch, par);
    line_bit(ch, 1'b1);
  endtask

  task automatic wait_drain();
    @(negedge clk);
    while (!all_drained()) begin
      @(negedge clk);
    end
    // rest of the last stop bit, and room for any stray frame
    repeat (BIT_CLKS * 2) @(negedge clk);
  endtask

  // decodes one tx line at mid-bit
  task automatic monitor_tx(input int ch);
    uart_pkg::uart_byte_t got;
    uart_pkg::uart_byte_t exp;
    logic                 par;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      while (tx[ch] !== 1'b0) begin
        @(negedge clk);
      end
      repeat (BIT_CLKS / 2) @(negedge clk);
      check_bit($sformatf("tx[%0d] start bit", ch), tx[ch], 1'b0);
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CLKS) @(negedge clk);
        got[i] = tx[ch];
      end
      repeat (BIT_CLKS) @(negedge clk);
      par = tx[ch];
      repeat (BIT_CLKS) @(negedge clk);
      check_bit($sformatf("tx[%0d] stop bit", ch), tx[ch], 1'b1);
      if (exp_tx[ch].size() == 0) begin
        fail_run($sformatf("tx line %0d sent a frame that was never commanded", ch));
      end else begin
        exp = exp_tx[ch].pop_front();
        check_byte($sformatf("tx[%0d] byte", ch), got, exp);
        check_bit($sformatf("tx[%0d] parity bit", ch), par, odd_parity(got));
      end
    end
  endtask

  for (genvar g = 0; g < NUM_CH; g++) begin : g_mon
    initial monitor_tx(g);
  end

  always @(negedge clk) begin
    uart_pkg::chan_idx_t ch;
    ch = read_ch;
    if (rst_n === 1'b1 && read_rdy === 1'b1) begin
      if (solo_en) begin
        check_chan("read_ch", read_ch, solo_ch);
      end
      if (exp_rd[ch].size() == 0) begin
        fail_run($sformatf("read port gave a word for channel %0d with none due", ch));
      end else begin
        check_read("read_data", read_data, exp_rd[ch].pop_front());
      end
    end
  end

  initial begin
    #(WATCHDOG_NS);
    fail_run($sformatf("timeout after %0d ns, the DUT stopped making progress", WATCHDOG_NS));
  end

  initial begin
    logic [31:0] r;
    int          c;
    int          other;
    rst_n     = 1'b0;
    cmd_in    = '0;
    cmd_ch    = '0;
    cmd_vld   = 1'b0;
    loop_en   = '0;
    inj_line  = '1;
    solo_en   = 1'b0;
    solo_ch   = '0;
    lcg_state = 32'h60002d45;
    repeat (10) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // reset state
    for (int ch = 0; ch < NUM_CH; ch++) begin
      @(posedge clk);
      #1;
      cmd_ch = uart_pkg::chan_idx_t'(ch);
      @(negedge clk);
      check_bit($sformatf("cmd_rdy for cmd_ch %0d", ch), cmd_rdy, 1'b1);
      check_bit($sformatf("tx[%0d]", ch), tx[ch], 1'b1);
      check_bit("read_rdy", read_rdy, 1'b0);
    end

    // single command, no loopback
    r = next_rand();
    c = int'(r[31:24]) % NUM_CH;
    r = next_rand();
    issue_cmd(c, r[31:16]);
    wait_drain();

    // loopback on one channel
    loop_en = '1;
    r       = next_rand();
    c       = int'(r[31:24]) % NUM_CH;
    solo_ch = uart_pkg::chan_idx_t'(c);
    solo_en = 1'b1;
    for (int k = 0; k < 2; k++) begin
      r = next_rand();
      issue_cmd(c, r[31:16]);
    end
    wait_drain();

    // injected frames, some with flipped parity
    loop_en = '0;
    r       = next_rand();
    c       = int'(r[31:24]) % NUM_CH;
    solo_ch = uart_pkg::chan_idx_t'(c);
    for (int k = 0; k < 6; k++) begin
      r = next_rand();
      send_serial(c, r[31:24], (k == 1) || (k > 1 && r[20]));
    end
    wait_drain();
    solo_en = 1'b0;

    // a command held on a busy channel
    r     = next_rand();
    c     = int'(r[31:24]) % NUM_CH;
    other = (c + 1) % NUM_CH;
    r     = next_rand();
    issue_cmd(c, r[31:16]);
    cmd_ch = uart_pkg::chan_idx_t'(other);
    @(negedge clk);
    check_bit("cmd_rdy on idle channel", cmd_rdy, 1'b1);
    @(posedge clk);
    #1;
    cmd_ch = uart_pkg::chan_idx_t'(c);
    repeat (BIT_CLKS * 4) begin
      @(negedge clk);
      check_bit("cmd_rdy on busy channel", cmd_rdy, 1'b0);
    end
    r = next_rand();
    issue_cmd(c, r[31:16]);
    wait_drain();

    // every channel under loopback, two rounds
    loop_en = '1;
    for (int round = 0; round < 2; round++) begin
      for (int ch = 0; ch < NUM_CH; ch++) begin
        r = next_rand();
        issue_cmd(ch, r[31:16]);
      end
    end
    wait_drain();

    // long enough for a repeated frame to reach its stop bit
    repeat (2 * `UART_FRAME_BITS * BIT_CLKS) @(negedge clk);
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* build.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/baud_tick_gen.sv
verilog/cmd_dispatch.sv
verilog/uart_tx_frame.sv
verilog/uart_rx_frame.sv
verilog/read_arbiter.sv
verilog/uart_cmd_top.sv
sim/tb_uart_cmd.sv

/* run_sim.sh */
#!/bin/sh
# builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
  --top-module tb_uart_cmd -f build.f -o tb_uart_cmd \
  && ./obj_dir/tb_uart_cmd \
  || exit 1
